//--- all.f
hw/cpu_isa_pkg.sv
hw/cpu_bus_pkg.sv
hw/fetch_ctrl.sv
hw/insn_fetch_axil.sv
hw/if_reg.sv
hw/fetch_top.sv
test/axil_mem_model.sv
test/tb_fetch_top.sv

//--- hw/cpu_bus_pkg.sv
/*
 * AXI4-Lite read-channel definitions for the fetch unit.
 * Channel payloads travel as packed structs; valid and
 * ready stay as separate wires next to them.
 */

package cpu_bus_pkg;

    import cpu_isa_pkg::*;

    localparam int RESP_W = 2;                        // xRESP width
    localparam int PROT_W = 3;                        // AxPROT width

    typedef logic [RESP_W-1:0] axil_resp_t;           // Read response code
    typedef logic [PROT_W-1:0] axil_prot_t;           // Access protection bits

    localparam axil_resp_t RESP_OKAY   = 2'b00;       // Normal access done
    localparam axil_resp_t RESP_SLVERR = 2'b10;       // Slave error

    // Unprivileged, secure, instruction access
    localparam axil_prot_t AR_PROT_INSN = 3'b100;

    // Read-address channel payload, 35 bits
    typedef struct packed {
        word_t      addr;                             // Byte address of the word
        axil_prot_t prot;                             // Always AR_PROT_INSN here
    } axil_ar_t;

    // Read-data channel payload, 34 bits
    typedef struct packed {
        insn_t      data;                             // Returned instruction
        axil_resp_t resp;                             // OKAY or SLVERR
    } axil_r_t;

endpackage

//--- hw/cpu_isa_pkg.sv
/*
 * ISA-level definitions for the 32-bit RISC pipeline.
 * Word and instruction widths, reset PC, NOP encoding
 * and the IF/ID payload handed to the decode stage.
 */

package cpu_isa_pkg;

    localparam int WORD_W = 32;                       // Data and address width
    localparam int INSN_W = 32;                       // Instruction width

    typedef logic [WORD_W-1:0] word_t;                // PC or byte address
    typedef logic [INSN_W-1:0] insn_t;                // Raw instruction word

    localparam insn_t ISA_NOP  = 32'h0000_0013;       // addi x0, x0, 0
    localparam word_t RESET_PC = '0;                  // Boot address
    localparam word_t PC_STEP  = 32'd4;               // One instruction per word

    // Payload of the IF/ID pipeline register, 66 bits
    typedef struct packed {
        word_t pc;                                    // Address of this instruction
        insn_t insn;                                  // Fetched instruction
        logic  valid;                                 // Pipeline-effective mark
        logic  fault;                                 // Bus error on this fetch
    } if_id_t;

endpackage

//--- hw/fetch_ctrl.sv
/*
 * Fetch pipeline control.
 * Keeps a redirect that arrives under a stall until the stall
 * drops, then decides advance, redirect and buffer discard.
 */

`timescale 1ns/1ns

module fetch_ctrl import cpu_isa_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  id_stall,                           // Decode back-pressure
    input  logic  flush,                              // Pipeline flush request
    input  word_t new_pc,                             // Flush target
    input  logic  br_taken,                           // Taken branch
    input  word_t br_addr,                            // Branch target
    input  logic  buf_valid,                          // Fetch buffer holds an insn
    output logic  hold,                               // Freeze IF/ID
    output logic  advance,                            // Move buffer into IF/ID
    output logic  pop,                                // Release the fetch buffer
    output logic  redir_valid,                        // Apply a redirect now
    output word_t redir_pc,                           // Redirect target
    output logic  discard                             // Drop buffered or in-flight data
);

    logic  req_valid;                                 // New redirect this cycle
    word_t req_pc;                                    // Its target
    logic  pend_valid;                                // Redirect waiting on a stall
    word_t pend_pc;

    assign req_valid = flush | br_taken;
    assign req_pc    = flush ? new_pc : br_addr;      // Flush beats branch

    // Pending flag, set under stall and spent once the stall drops
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pend_valid <= 1'b0;
        end else if (id_stall) begin
            if (req_valid) begin
                pend_valid <= 1'b1;
            end
        end else begin
            pend_valid <= 1'b0;                       // Presented this cycle
        end
    end

    // Newest request overwrites an older pending target
    always_ff @(posedge clk) begin
        if (id_stall && req_valid) begin
            pend_pc <= req_pc;
        end
    end

    assign hold        = id_stall;
    assign redir_valid = !id_stall && (req_valid || pend_valid);
    assign redir_pc    = req_valid ? req_pc : pend_pc; // Live request wins
    assign advance     = buf_valid && !id_stall && !redir_valid;
    assign pop         = advance;                     // Same event, fetch side
    assign discard     = redir_valid;                 // Old path is dead

    // A redirect and a capture into IF/ID would fight over if_pc
    a_no_adv_redir: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(advance && redir_valid)
    ) else $error("advance and redir_valid high together");

endmodule

//--- hw/fetch_top.sv
/*
 * Instruction fetch stage top level.
 * Ties the pipeline control, the AXI4-Lite fetch master
 * and the IF/ID register together.
 */

`timescale 1ns/1ns

module fetch_top import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    output axil_ar_t mem_ar,                          // Read address
    output logic     mem_ar_valid,
    input  logic     mem_ar_ready,
    input  axil_r_t  mem_r,                           // Read data
    input  logic     mem_r_valid,
    output logic     mem_r_ready,
    input  logic     id_stall,
    input  logic     flush,
    input  word_t    new_pc,
    input  logic     br_taken,
    input  word_t    br_addr,
    output if_id_t   id,
    output word_t    if_pc
);

    logic  buf_valid;                                 // Fetch buffer state
    insn_t buf_insn;
    logic  buf_fault;
    logic  hold;
    logic  advance;
    logic  pop;
    logic  redir_valid;
    word_t redir_pc;
    logic  discard;

    fetch_ctrl i_fetch_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .id_stall    (id_stall),
        .flush       (flush),
        .new_pc      (new_pc),
        .br_taken    (br_taken),
        .br_addr     (br_addr),
        .buf_valid   (buf_valid),
        .hold        (hold),
        .advance     (advance),
        .pop         (pop),
        .redir_valid (redir_valid),
        .redir_pc    (redir_pc),
        .discard     (discard)
    );

    insn_fetch_axil i_insn_fetch_axil (
        .clk          (clk),
        .rst_n        (rst_n),
        .fetch_addr   (if_pc),                        // Fetch from IF/ID PC
        .pop          (pop),
        .discard      (discard),
        .buf_valid    (buf_valid),
        .buf_insn     (buf_insn),
        .buf_fault    (buf_fault),
        .mem_ar       (mem_ar),
        .mem_ar_valid (mem_ar_valid),
        .mem_ar_ready (mem_ar_ready),
        .mem_r        (mem_r),
        .mem_r_valid  (mem_r_valid),
        .mem_r_ready  (mem_r_ready)
    );

    if_reg i_if_reg (
        .clk         (clk),
        .rst_n       (rst_n),
        .hold        (hold),
        .advance     (advance),
        .redir_valid (redir_valid),
        .redir_pc    (redir_pc),
        .buf_insn    (buf_insn),
        .buf_fault   (buf_fault),
        .if_pc       (if_pc),
        .id          (id)
    );

endmodule

//--- hw/if_reg.sv
/*
 * IF/ID pipeline register.
 * Holds the fetch PC and the instruction handed to decode;
 * stall freezes it, a redirect loads a new PC and a bubble.
 */

`timescale 1ns/1ns

module if_reg import cpu_isa_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   hold,                              // Decode stall
    input  logic   advance,                           // Capture buffered insn
    input  logic   redir_valid,                       // Flush or branch applied
    input  word_t  redir_pc,                          // New fetch PC
    input  insn_t  buf_insn,                          // From fetch buffer
    input  logic   buf_fault,
    output word_t  if_pc,                             // Next address to fetch
    output if_id_t id                                 // To decode
);

    localparam if_id_t ID_BUBBLE = '{
        pc:    RESET_PC,
        insn:  ISA_NOP,
        valid: 1'b0,
        fault: 1'b0
    };

    // Fetch PC
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            if_pc <= RESET_PC;
        end else if (!hold) begin
            if (redir_valid) begin
                if_pc <= redir_pc;                    // Jump to new path
            end else if (advance) begin
                if_pc <= if_pc + PC_STEP;             // Sequential fetch
            end
        end
    end

    // Decode-stage instruction
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id <= ID_BUBBLE;
        end else if (!hold) begin
            if (redir_valid) begin
                id.insn  <= ISA_NOP;                  // Kill whatever was there
                id.valid <= 1'b0;
                id.fault <= 1'b0;
            end else if (advance) begin
                id.pc    <= if_pc;
                id.insn  <= buf_insn;
                id.valid <= 1'b1;
                id.fault <= buf_fault;
            end else begin
                id.insn  <= ISA_NOP;                  // Bubble, buffer empty
                id.valid <= 1'b0;
                id.fault <= 1'b0;
            end
        end
    end

    // Fault comes from the fetch master two stages back
    a_fault_nop: assert property (
        @(posedge clk) disable iff (!rst_n)
        id.fault |-> (id.insn == ISA_NOP)
    ) else $error("faulting fetch carries a non-NOP instruction");

endmodule

//--- hw/insn_fetch_axil.sv
/*
 * AXI4-Lite instruction fetch master.
 * One read in flight, one-entry instruction buffer. A redirect
 * marks an in-flight read stale; error responses become a faulting NOP.
 */

`timescale 1ns/1ns

module insn_fetch_axil import cpu_isa_pkg::*, cpu_bus_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  word_t    fetch_addr,                      // if_pc from IF/ID
    input  logic     pop,                             // Buffer consumed
    input  logic     discard,                         // Redirect applied now
    output logic     buf_valid,                       // Buffer holds an insn
    output insn_t    buf_insn,
    output logic     buf_fault,                       // Buffered insn came with error
    output axil_ar_t mem_ar,
    output logic     mem_ar_valid,
    input  logic     mem_ar_ready,
    input  axil_r_t  mem_r,
    input  logic     mem_r_valid,
    output logic     mem_r_ready
);

    typedef enum logic [1:0] {
        IDLE,                                         // Nothing in flight, buffer empty
        ADDR,                                         // AR presented
        DATA,                                         // Waiting on R
        FULL                                          // Buffer holds an insn
    } state_t;

    state_t state;
    state_t state_nxt;
    word_t  ar_addr;                                  // Latched fetch address
    logic   stale;                                    // In-flight read is off-path
    logic   ar_done;                                  // AR handshake
    logic   r_done;                                   // R handshake
    logic   drop_rsp;                                 // Response goes nowhere
    logic   rsp_err;                                  // Slave reported an error

    assign ar_done  = mem_ar_valid && mem_ar_ready;
    assign r_done   = mem_r_valid && mem_r_ready;
    assign drop_rsp = stale || discard;
    assign rsp_err  = (mem_r.resp == RESP_SLVERR);

    always_comb begin
        state_nxt = state;
        case (state)
            IDLE: begin
                if (!discard) begin
                    state_nxt = ADDR;                 // if_pc settled, go fetch
                end
            end
            ADDR: begin
                if (ar_done) begin
                    state_nxt = DATA;
                end
            end
            DATA: begin
                if (r_done) begin
                    state_nxt = drop_rsp ? IDLE : FULL;
                end
            end
            FULL: begin
                if (pop || discard) begin
                    state_nxt = IDLE;                 // Consumed or flushed
                end
            end
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // Stale mark lives until its response is swallowed
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stale <= 1'b0;
        end else if (r_done) begin
            stale <= 1'b0;
        end else if (discard && (state == ADDR || state == DATA)) begin
            stale <= 1'b1;
        end
    end

    // Address is frozen from IDLE exit until AR is accepted
    always_ff @(posedge clk) begin
        if (state == IDLE && !discard) begin
            ar_addr <= fetch_addr;
        end
    end

    always_ff @(posedge clk) begin
        if (r_done && !drop_rsp) begin
            buf_insn  <= rsp_err ? ISA_NOP : mem_r.data;  // Fault turns into NOP
            buf_fault <= rsp_err;
        end
    end

    assign mem_ar       = '{addr: ar_addr, prot: AR_PROT_INSN};
    assign mem_ar_valid = (state == ADDR);
    assign mem_r_ready  = (state == DATA);            // Always ready once outstanding
    assign buf_valid    = (state == FULL);

    // AXI rule, payload holds until the slave takes it
    a_ar_stable: assert property (
        @(posedge clk) disable iff (!rst_n)
        (mem_ar_valid && !mem_ar_ready) |=> (mem_ar_valid && $stable(mem_ar))
    ) else $error("AR dropped or changed before acceptance");

    a_one_in_flight: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(buf_valid && (mem_r_ready || mem_ar_valid))
    ) else $error("read issued while buffer full");

endmodule

//--- run.sh
#!/bin/sh
# Build and run the fetch stage testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module tb_fetch_top -f all.f

# A crashed or stopped run simply lacks the pass line
sim_out="$(./obj_dir/Vtb_fetch_top)" || true
echo "$sim_out"

if printf '%s\n' "$sim_out" | grep -qx "TESTS PASSED"; then
    exit 0
fi
exit 1

//--- test/axil_mem_model.sv
/*
 * AXI4-Lite read slave model for the fetch testbench.
 * Each word holds its address XOR A5A5_0000, SLVERR from LIMIT up,
 * AR and R latency of 0 to 5 cycles from an LCG.
 */

`timescale 1ns/1ns

module axil_mem_model import cpu_isa_pkg::*, cpu_bus_pkg::*; #(
    parameter word_t       LIMIT = 32'h0000_0400,     // First erroring address
    parameter logic [31:0] SEED  = 32'h423b
) (
    input  logic     clk,
    input  logic     rst_n,
    input  axil_ar_t ar,
    input  logic     ar_valid,
    output logic     ar_ready,
    output axil_r_t  r,
    output logic     r_valid,
    input  logic     r_ready
);

    logic [31:0] lcg_state;
    logic [2:0]  ar_wait;                             // Cycles left before AR ready
    logic [2:0]  r_wait;                              // Cycles left before R valid
    logic        busy;                                // Address taken, data owed
    word_t       rd_addr;

    function logic [2:0] next_latency();
        logic [31:0] v;
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        v = (lcg_state >> 16) % 32'd6;                // Upper bits, 0 to 5
        return v[2:0];
    endfunction

    always @(posedge clk) begin
        if (!rst_n) begin
            lcg_state = SEED;
            ar_ready <= 1'b0;
            r_valid  <= 1'b0;
            busy     <= 1'b0;
            ar_wait  <= 3'd0;
            r_wait   <= 3'd0;
        end else begin
            if (ar_valid && ar_ready) begin
                ar_ready <= 1'b0;                     // Address accepted
                busy     <= 1'b1;
                rd_addr  <= ar.addr;
                r_wait   <= next_latency();
            end else if (ar_valid && !busy) begin
                if (ar_wait == 3'd0) begin
                    ar_ready <= 1'b1;
                    ar_wait  <= next_latency();       // Delay for the next request
                end else begin
                    ar_wait <= ar_wait - 3'd1;
                end
            end
            if (r_valid && r_ready) begin
                r_valid <= 1'b0;                      // Data taken
                busy    <= 1'b0;
            end else if (busy && !r_valid) begin
                if (r_wait == 3'd0) begin
                    r_valid <= 1'b1;
                    r.data  <= (rd_addr >= LIMIT) ? 32'hFFFF_FFFF : (rd_addr ^ 32'hA5A5_0000);
                    r.resp  <= (rd_addr >= LIMIT) ? RESP_SLVERR : RESP_OKAY;
                end else begin
                    r_wait <= r_wait - 3'd1;
                end
            end
        end
    end

endmodule

//--- test/tb_fetch_top.sv
/*
 * Testbench for the instruction fetch stage.
 * Reference PC model plus concurrent checks on every handoff to decode.
 */

`timescale 1ns/1ns

module tb_fetch_top import cpu_isa_pkg::*, cpu_bus_pkg::*; ();

    localparam word_t       MEM_LIMIT = 32'h0000_0400;  // SLVERR from here up
    localparam logic [31:0] SEED      = 32'h423b;

    logic        clk;
    logic        rst_n;
    axil_ar_t    mem_ar;
    logic        mem_ar_valid;
    logic        mem_ar_ready;
    axil_r_t     mem_r;
    logic        mem_r_valid;
    logic        mem_r_ready;
    logic        id_stall;
    logic        flush;
    word_t       new_pc;
    logic        br_taken;
    word_t       br_addr;
    if_id_t      id;
    word_t       if_pc;
    logic        stall_q;                             // id_stall at the last edge
    if_id_t      id_q;                                // id one cycle back
    word_t       exp_pc;                              // Next expected id.pc
    logic        pend_seen;                           // Redirect caught under stall
    word_t       pend_target;
    logic        fresh;                               // New instruction in IF/ID
    int          n_fresh;
    int          n_fault;
    int          err_cnt;
    int          err_mark;
    int          pass_cnt;
    int          fail_cnt;
    string       test_name;
    logic [31:0] rand_state;

    fetch_top i_fetch_top (.*);

    axil_mem_model #(
        .LIMIT (MEM_LIMIT),
        .SEED  (SEED)
    ) i_mem (
        .clk      (clk),
        .rst_n    (rst_n),
        .ar       (mem_ar),
        .ar_valid (mem_ar_valid),
        .ar_ready (mem_ar_ready),
        .r        (mem_r),
        .r_valid  (mem_r_valid),
        .r_ready  (mem_r_ready)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;                       // 40 ns period
    end

    function logic [31:0] next_rand();
        rand_state = rand_state * 32'd1103515245 + 32'd12345;
        return rand_state;
    endfunction

    // Memory contents as seen by decode, NOP past the limit
    function automatic insn_t mem_word(input word_t addr);
        return (addr >= MEM_LIMIT) ? ISA_NOP : (addr ^ 32'hA5A5_0000);
    endfunction

    assign fresh = id.valid && !stall_q;              // Held copies do not count

    always @(posedge clk) begin : pc_model
        logic  req;
        word_t req_pc;
        word_t nxt_pc;
        req    = flush || br_taken;
        req_pc = flush ? new_pc : br_addr;            // Flush wins
        nxt_pc = fresh ? exp_pc + PC_STEP : exp_pc;
        if (!rst_n) begin
            stall_q   <= 1'b0;
            id_q      <= '0;
            exp_pc    <= RESET_PC;
            pend_seen <= 1'b0;
            n_fresh   <= 0;
            n_fault   <= 0;
        end else begin
            stall_q <= id_stall;
            id_q    <= id;
            if (fresh) begin
                n_fresh <= n_fresh + 1;
            end
            if (fresh && id.fault) begin
                n_fault <= n_fault + 1;
            end
            if (id_stall) begin
                if (req) begin
                    pend_seen   <= 1'b1;
                    pend_target <= req_pc;            // Newer overwrites older
                end
            end else begin
                pend_seen <= 1'b0;
                if (req) begin
                    nxt_pc = req_pc;
                end else if (pend_seen) begin
                    nxt_pc = pend_target;             // Released after the stall
                end
            end
            exp_pc <= nxt_pc;
        end
    end

    a_handoff: assert property (@(posedge clk) disable iff (!rst_n)
        fresh |-> (id.pc == exp_pc && id.insn == mem_word(exp_pc)
                   && id.fault == (exp_pc >= MEM_LIMIT))
    ) else begin
        $display("FAIL %s: expected pc=%h insn=%h fault=%b actual pc=%h insn=%h fault=%b",
                 test_name, $sampled(exp_pc), mem_word($sampled(exp_pc)),
                 $sampled(exp_pc) >= MEM_LIMIT, $sampled(id.pc), $sampled(id.insn),
                 $sampled(id.fault));
        err_cnt++;
    end

    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        stall_q |-> (id == id_q)
    ) else begin
        $display("FAIL %s: held id expected %h actual %h", test_name, $sampled(id_q),
                 $sampled(id));
        err_cnt++;
    end

    // Every fetch is an instruction access
    a_ar_prot: assert property (@(posedge clk) disable iff (!rst_n)
        mem_ar_valid |-> (mem_ar.prot == AR_PROT_INSN)
    ) else begin
        $display("FAIL %s: AR prot expected %b actual %b", test_name, AR_PROT_INSN,
                 $sampled(mem_ar.prot));
        err_cnt++;
    end

    task automatic begin_test(input string name);
        test_name = name;
        err_mark  = err_cnt;
    endtask

    task automatic end_test();
        if (err_cnt == err_mark) begin
            $display("PASS %s", test_name);
            pass_cnt++;
        end else begin
            $display("FAIL %s: %0d errors", test_name, err_cnt - err_mark);
            fail_cnt++;
        end
    endtask

    task automatic wait_ids(input int count, input int limit);
        int target;
        int cycles;
        target = n_fresh + count;
        cycles = 0;
        while (n_fresh < target && cycles < limit) begin
            @(posedge clk);
            cycles++;
        end
        if (n_fresh < target) begin
            $display("%s: timed out after %0d cycles waiting for %0d instructions",
                     test_name, limit, count);
            err_cnt++;
        end
    endtask

    // One-cycle redirect request, seen by the DUT at the next edge
    task automatic pulse_redirect(input logic do_flush, input word_t flush_pc,
                                  input logic do_branch, input word_t target);
        flush    <= do_flush;
        new_pc   <= flush_pc;
        br_taken <= do_branch;
        br_addr  <= target;
        @(posedge clk);
        flush    <= 1'b0;
        br_taken <= 1'b0;
    endtask

    initial begin
        int          i;
        int          fault_mark;
        logic [31:0] r;
        rst_n      <= 1'b0;
        id_stall   <= 1'b0;
        flush      <= 1'b0;
        new_pc     <= '0;
        br_taken   <= 1'b0;
        br_addr    <= '0;
        err_cnt    = 0;
        pass_cnt   = 0;
        fail_cnt   = 0;
        rand_state = SEED;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;

        begin_test("reset_order");
        @(posedge clk);
        a_reset_idle: assert (!id.valid && if_pc == RESET_PC) else begin
            $display("FAIL %s: expected valid=0 pc=%h actual valid=%b pc=%h",
                     test_name, RESET_PC, id.valid, if_pc);
            err_cnt++;
        end
        wait_ids(8, 400);
        end_test();

        begin_test("stall_pulses");
        for (i = 0; i < 60; i++) begin
            r = next_rand();
            id_stall <= (r[31:29] < 3'd3);            // Stalls of varying length
            @(posedge clk);
        end
        id_stall <= 1'b0;
        wait_ids(8, 400);
        end_test();

        begin_test("branch_inflight");
        i = 0;
        while (!(mem_r_ready && !mem_r_valid) && i < 100) begin  // Read out, data not back
            @(posedge clk);
            i++;
        end
        if (!(mem_r_ready && !mem_r_valid)) begin
            $display("%s: no read waiting on data seen within 100 cycles", test_name);
            err_cnt++;
        end
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0100);
        wait_ids(6, 400);
        end_test();

        begin_test("flush_priority");
        pulse_redirect(1'b1, 32'h0000_0200, 1'b1, 32'h0000_0300);
        wait_ids(4, 400);
        id_stall <= 1'b1;
        repeat (2) @(posedge clk);
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0080);  // Branch under stall
        repeat (3) @(posedge clk);
        id_stall <= 1'b0;
        wait_ids(6, 400);
        end_test();

        begin_test("fault_at_limit");
        fault_mark = n_fault;
        pulse_redirect(1'b0, '0, 1'b1, MEM_LIMIT - 32'd8);
        wait_ids(6, 400);
        if (n_fault == fault_mark) begin
            $display("%s: no faulting fetch seen past the memory limit", test_name);
            err_cnt++;
        end
        end_test();

        begin_test("random_latency");
        pulse_redirect(1'b0, '0, 1'b1, 32'h0000_0040);
        for (i = 0; i < 400; i++) begin
            r = next_rand();
            id_stall <= (r[31:30] == 2'b00);
            br_taken <= (r[29:25] == 5'd0);
            flush    <= (r[24:20] == 5'd0);
            br_addr  <= {22'd0, r[19:12], 2'b00};
            new_pc   <= {22'd0, r[11:4], 2'b00};
            @(posedge clk);
        end
        id_stall <= 1'b0;
        br_taken <= 1'b0;
        flush    <= 1'b0;
        wait_ids(20, 1000);
        end_test();

        $display("Summary: %0d passing, %0d failing, %0d errors", pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule
